//--- src/hog_cell_pkg.sv
// shared sizes, state, bank and vote-slot encodings for the HOG cell-histogram RTL and bench
package hog_cell_pkg;

	//--------------------------------------------------
	// default sizes, overridden from the top level
	//--------------------------------------------------
	parameter int default_cells_per_side = 34; // cells along one grid side
	parameter int default_num_bins = 18; // orientation bins per cell
	parameter int default_acc_width = 35; // accumulator and intensity width
	parameter int cell_px_bits = 2; // 4x4 pixels per cell

	//--------------------------------------------------
	// encodings
	//--------------------------------------------------
	typedef enum logic {
		st_clear, // zeroing all banks
		st_idle // accepting votes and readback
	} ctrl_state_e;

	// bank by {row parity, col parity}
	typedef enum logic [1:0] {
		bank_odd_odd = 2'd0,
		bank_odd_even = 2'd1,
		bank_even_odd = 2'd2,
		bank_even_even = 2'd3
	} bank_e;

	// order matches intensity_0 to intensity_3
	typedef enum logic [1:0] {
		slot_own = 2'd0, // cell holding the pixel
		slot_vert = 2'd1, // up or down neighbour
		slot_diag = 2'd2, // corner neighbour
		slot_horz = 2'd3 // left or right neighbour
	} slot_e;

endpackage

//--- src/hist_bank.sv
// one simple dual-port histogram bank, registered read port and write port
`timescale 1ns/1ps

module hist_bank #(
	parameter int cells_per_side = hog_cell_pkg::default_cells_per_side,
	parameter int num_bins = hog_cell_pkg::default_num_bins,
	parameter int acc_width = hog_cell_pkg::default_acc_width,
	localparam int half = (cells_per_side + 1) / 2,
	localparam int depth = half * half * num_bins,
	localparam int aw = $clog2(depth)
) (
	input logic aclk,
	input logic [aw-1:0] raddr,
	input logic we,
	input logic [aw-1:0] waddr,
	input logic [acc_width-1:0] wdata,
	output logic [acc_width-1:0] rdata
);

	logic [acc_width-1:0] mem [depth];

	always_ff @(posedge aclk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
		rdata <= mem[raddr]; // read-first on a collision
	end

endmodule

//--- src/clear_addr_counter.sv
// walks every bank address once per clear, flagging the last one to the FSM and datapath
`timescale 1ns/1ps

module clear_addr_counter #(
	parameter int cells_per_side = hog_cell_pkg::default_cells_per_side,
	parameter int num_bins = hog_cell_pkg::default_num_bins,
	localparam int half = (cells_per_side + 1) / 2,
	localparam int depth = half * half * num_bins,
	localparam int aw = $clog2(depth)
) (
	input logic aclk,
	input logic rst,
	input logic clear_en,
	output logic [aw-1:0] clear_addr,
	output logic clear_last
);

	assign clear_last = clear_en & (clear_addr == aw'(depth - 1)); // final word

	always_ff @(posedge aclk) begin
		if (rst) begin
			clear_addr <= '0;
		end else if (clear_last) begin
			clear_addr <= '0; // ready for next clear
		end else if (clear_en) begin
			clear_addr <= clear_addr + 1'b1;
		end
	end

endmodule

//--- src/cell_hist_ctrl.sv
// control FSM for clear/idle, vote and readback acceptance, and the frame_done pulse
`timescale 1ns/1ps

module cell_hist_ctrl #(
	parameter int cells_per_side = hog_cell_pkg::default_cells_per_side,
	localparam int pw = $clog2(cells_per_side) + hog_cell_pkg::cell_px_bits
) (
	input logic aclk,
	input logic rst,
	input logic clear_start,
	input logic clear_last,
	input logic vote_valid,
	input logic [pw-1:0] vote_row,
	input logic [pw-1:0] vote_col,
	input logic rd_valid,
	output logic clear_en,
	output logic vote_ready,
	output logic vote_accept,
	output logic rd_ready,
	output logic rd_accept,
	output logic hist_ready,
	output logic frame_done
);

	localparam logic [pw-1:0] last_px = pw'(cells_per_side * (1 << hog_cell_pkg::cell_px_bits) - 1);

	hog_cell_pkg::ctrl_state_e state;
	logic in_flight; // vote accepted last edge, write not yet done
	logic last_px_q; // last-pixel vote in its read cycle

	assign clear_en = (state == hog_cell_pkg::st_clear);
	assign vote_ready = (state == hog_cell_pkg::st_idle);
	assign vote_accept = vote_valid & vote_ready;
	assign rd_ready = vote_ready & ~vote_valid & ~in_flight; // votes win
	assign rd_accept = rd_valid & rd_ready;

	//--------------------------------------------------
	// state machine
	//--------------------------------------------------
	always_ff @(posedge aclk) begin
		if (rst) begin
			state <= hog_cell_pkg::st_clear; // banks cleared after reset
			hist_ready <= 1'b0;
		end else begin
			case (state)
				hog_cell_pkg::st_clear: begin
					if (clear_last) begin
						state <= hog_cell_pkg::st_idle;
						hist_ready <= 1'b1;
					end
				end
				default: begin
					if (clear_start) begin // re-clear on request
						state <= hog_cell_pkg::st_clear;
						hist_ready <= 1'b0;
					end
				end
			endcase
		end
	end

	// frame_done lands in the write cycle of the last-pixel vote
	always_ff @(posedge aclk) begin
		if (rst) begin
			in_flight <= 1'b0;
			last_px_q <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			in_flight <= vote_accept;
			last_px_q <= vote_accept & (vote_row == last_px) & (vote_col == last_px);
			frame_done <= last_px_q;
		end
	end

endmodule

//--- src/vote_addr_gen.sv
// combinational vote cell addressing, edge checks, bank steering and readback address
`timescale 1ns/1ps

module vote_addr_gen #(
	parameter int cells_per_side = hog_cell_pkg::default_cells_per_side,
	parameter int num_bins = hog_cell_pkg::default_num_bins,
	localparam int cw = $clog2(cells_per_side),
	localparam int pw = cw + hog_cell_pkg::cell_px_bits,
	localparam int bw = $clog2(num_bins),
	localparam int half = (cells_per_side + 1) / 2,
	localparam int aw = $clog2(half * half * num_bins)
) (
	input logic [pw-1:0] vote_row,
	input logic [pw-1:0] vote_col,
	input logic [bw-1:0] vote_bin,
	input logic [cw-1:0] rd_cell_row,
	input logic [cw-1:0] rd_cell_col,
	input logic [bw-1:0] rd_bin,
	output logic [aw-1:0] bank_addr_0,
	output logic [aw-1:0] bank_addr_1,
	output logic [aw-1:0] bank_addr_2,
	output logic [aw-1:0] bank_addr_3,
	output hog_cell_pkg::slot_e bank_slot_0,
	output hog_cell_pkg::slot_e bank_slot_1,
	output hog_cell_pkg::slot_e bank_slot_2,
	output hog_cell_pkg::slot_e bank_slot_3,
	output logic bank_slot_ok_0,
	output logic bank_slot_ok_1,
	output logic bank_slot_ok_2,
	output logic bank_slot_ok_3,
	output hog_cell_pkg::bank_e rd_bank,
	output logic [aw-1:0] rd_addr
);

	localparam int pb = hog_cell_pkg::cell_px_bits;

	// address inside the parity bank
	function automatic logic [aw-1:0] cell_addr(input logic [cw-1:0] r, input logic [cw-1:0] c,
			input logic [bw-1:0] b);
		cell_addr = (aw'(r >> 1) * aw'(half) + aw'(c >> 1)) * aw'(num_bins) + aw'(b);
	endfunction

	function automatic hog_cell_pkg::bank_e bank_of(input logic [cw-1:0] r, input logic [cw-1:0] c);
		bank_of = hog_cell_pkg::bank_e'({~r[0], ~c[0]}); // odd,odd is bank 0
	endfunction

	logic [cw-1:0] cell_r, cell_c; // own cell
	logic [cw-1:0] nb_r, nb_c; // neighbour row and col
	logic upper, left; // pixel quadrant inside cell
	logic r_ok, c_ok; // neighbour row/col inside grid
	logic [3:0][cw-1:0] s_r, s_c; // per-slot cell
	logic [3:0] s_ok;
	logic [3:0][aw-1:0] addr;
	hog_cell_pkg::slot_e slot [4];
	logic [3:0] ok;
	hog_cell_pkg::bank_e bk;

	assign cell_r = vote_row[pw-1:pb];
	assign cell_c = vote_col[pw-1:pb];
	assign upper = ~vote_row[pb-1];
	assign left = ~vote_col[pb-1];
	assign nb_r = upper ? cell_r - 1'b1 : cell_r + 1'b1;
	assign nb_c = left ? cell_c - 1'b1 : cell_c + 1'b1;
	assign r_ok = upper ? (cell_r != '0) : (cell_r != cw'(cells_per_side - 1));
	assign c_ok = left ? (cell_c != '0) : (cell_c != cw'(cells_per_side - 1));

	// own, vert, diag, horz in slot order
	assign s_r = {cell_r, nb_r, nb_r, cell_r};
	assign s_c = {nb_c, nb_c, cell_c, cell_c};
	assign s_ok = {c_ok, r_ok & c_ok, r_ok, 1'b1};

	// the four cells always fall in four different banks
	always_comb begin
		addr = '0;
		ok = '0;
		for (int b = 0; b < 4; b++) begin
			slot[b] = hog_cell_pkg::slot_own;
		end
		for (int s = 0; s < 4; s++) begin
			bk = bank_of(s_r[s], s_c[s]);
			addr[bk] = cell_addr(s_r[s], s_c[s], vote_bin);
			slot[bk] = hog_cell_pkg::slot_e'(2'(s));
			ok[bk] = s_ok[s];
		end
	end

	assign {bank_addr_3, bank_addr_2, bank_addr_1, bank_addr_0} = addr;
	assign {bank_slot_ok_3, bank_slot_ok_2, bank_slot_ok_1, bank_slot_ok_0} = ok;
	assign bank_slot_0 = slot[0];
	assign bank_slot_1 = slot[1];
	assign bank_slot_2 = slot[2];
	assign bank_slot_3 = slot[3];

	assign rd_bank = bank_of(rd_cell_row, rd_cell_col); // readback cell
	assign rd_addr = cell_addr(rd_cell_row, rd_cell_col, rd_bin);

endmodule

//--- src/vote_accumulate.sv
// read-modify-write pipeline over the four banks, with bypass, clear writes and readback mux
`timescale 1ns/1ps

module vote_accumulate #(
	parameter int cells_per_side = hog_cell_pkg::default_cells_per_side,
	parameter int num_bins = hog_cell_pkg::default_num_bins,
	parameter int acc_width = hog_cell_pkg::default_acc_width,
	localparam int half = (cells_per_side + 1) / 2,
	localparam int aw = $clog2(half * half * num_bins)
) (
	input logic aclk,
	input logic rst,
	input logic vote_accept,
	input logic rd_accept,
	input logic clear_en,
	input logic [aw-1:0] clear_addr,
	input logic [aw-1:0] bank_addr_0,
	input logic [aw-1:0] bank_addr_1,
	input logic [aw-1:0] bank_addr_2,
	input logic [aw-1:0] bank_addr_3,
	input hog_cell_pkg::slot_e bank_slot_0,
	input hog_cell_pkg::slot_e bank_slot_1,
	input hog_cell_pkg::slot_e bank_slot_2,
	input hog_cell_pkg::slot_e bank_slot_3,
	input logic bank_slot_ok_0,
	input logic bank_slot_ok_1,
	input logic bank_slot_ok_2,
	input logic bank_slot_ok_3,
	input logic [acc_width-1:0] vote_intensity_0,
	input logic [acc_width-1:0] vote_intensity_1,
	input logic [acc_width-1:0] vote_intensity_2,
	input logic [acc_width-1:0] vote_intensity_3,
	input hog_cell_pkg::bank_e rd_bank,
	input logic [aw-1:0] rd_addr,
	input logic [acc_width-1:0] bank_rdata_0,
	input logic [acc_width-1:0] bank_rdata_1,
	input logic [acc_width-1:0] bank_rdata_2,
	input logic [acc_width-1:0] bank_rdata_3,
	output logic [aw-1:0] bank_raddr_0,
	output logic [aw-1:0] bank_raddr_1,
	output logic [aw-1:0] bank_raddr_2,
	output logic [aw-1:0] bank_raddr_3,
	output logic bank_we_0,
	output logic bank_we_1,
	output logic bank_we_2,
	output logic bank_we_3,
	output logic [aw-1:0] bank_waddr_0,
	output logic [aw-1:0] bank_waddr_1,
	output logic [aw-1:0] bank_waddr_2,
	output logic [aw-1:0] bank_waddr_3,
	output logic [acc_width-1:0] bank_wdata_0,
	output logic [acc_width-1:0] bank_wdata_1,
	output logic [acc_width-1:0] bank_wdata_2,
	output logic [acc_width-1:0] bank_wdata_3,
	output logic rd_resp_valid,
	output logic [acc_width-1:0] rd_resp_data
);

	logic [3:0][aw-1:0] vaddr, raddr_q, waddr_q, waddr, prev_waddr;
	logic [3:0][acc_width-1:0] intens, int_q1, int_q2, rdata, old_val, wdata, prev_wdata;
	hog_cell_pkg::slot_e slot_in [4], slot_q1 [4], slot_q2 [4];
	logic [3:0] ok_in, ok_q1, ok_q2, we, prev_we;
	logic v_q1, v_q2; // vote in read cycle, in write cycle
	logic rd_q1; // readback in read cycle
	hog_cell_pkg::bank_e rd_bank_q1, rd_bank_q2;

	assign vaddr = {bank_addr_3, bank_addr_2, bank_addr_1, bank_addr_0};
	assign intens = {vote_intensity_3, vote_intensity_2, vote_intensity_1, vote_intensity_0};
	assign rdata = {bank_rdata_3, bank_rdata_2, bank_rdata_1, bank_rdata_0};
	assign ok_in = {bank_slot_ok_3, bank_slot_ok_2, bank_slot_ok_1, bank_slot_ok_0};
	assign slot_in = '{bank_slot_0, bank_slot_1, bank_slot_2, bank_slot_3};

	//--------------------------------------------------
	// pipeline control
	//--------------------------------------------------
	always_ff @(posedge aclk) begin
		if (rst) begin
			v_q1 <= 1'b0;
			v_q2 <= 1'b0;
			rd_q1 <= 1'b0;
			rd_resp_valid <= 1'b0;
			prev_we <= '0;
		end else begin
			v_q1 <= vote_accept;
			v_q2 <= v_q1;
			rd_q1 <= rd_accept;
			rd_resp_valid <= rd_q1; // bank data out this cycle
			prev_we <= we;
		end
	end

	// payload, no reset
	always_ff @(posedge aclk) begin
		if (vote_accept) begin
			raddr_q <= vaddr;
		end else if (rd_accept) begin
			raddr_q <= {4{rd_addr}}; // same word in all banks
		end
		int_q1 <= intens;
		slot_q1 <= slot_in;
		ok_q1 <= ok_in;
		rd_bank_q1 <= rd_bank;
		waddr_q <= raddr_q;
		int_q2 <= int_q1;
		slot_q2 <= slot_q1;
		ok_q2 <= ok_q1;
		rd_bank_q2 <= rd_bank_q1;
		prev_waddr <= waddr;
		prev_wdata <= wdata;
	end

	//--------------------------------------------------
	// write cycle
	//--------------------------------------------------
	always_comb begin
		for (int b = 0; b < 4; b++) begin
			// bank read saw stale data if last write hit the same word
			old_val[b] = (prev_we[b] && prev_waddr[b] == waddr_q[b]) ? prev_wdata[b] : rdata[b];
			if (clear_en) begin
				we[b] = 1'b1;
				waddr[b] = clear_addr;
				wdata[b] = '0;
			end else begin
				we[b] = v_q2 & ok_q2[b]; // off-grid neighbour skipped
				waddr[b] = waddr_q[b];
				wdata[b] = old_val[b] + int_q2[slot_q2[b]];
			end
		end
	end

	assign {bank_raddr_3, bank_raddr_2, bank_raddr_1, bank_raddr_0} = raddr_q;
	assign {bank_we_3, bank_we_2, bank_we_1, bank_we_0} = we;
	assign {bank_waddr_3, bank_waddr_2, bank_waddr_1, bank_waddr_0} = waddr;
	assign {bank_wdata_3, bank_wdata_2, bank_wdata_1, bank_wdata_0} = wdata;
	assign rd_resp_data = rdata[rd_bank_q2];

endmodule

//--- src/cell_hist_top.sv
// HOG cell-histogram accumulator top, sets sizes and wires FSM, datapath and four banks
`timescale 1ns/1ps

module cell_hist_top #(
	parameter int cells_per_side = hog_cell_pkg::default_cells_per_side,
	parameter int num_bins = hog_cell_pkg::default_num_bins,
	parameter int acc_width = hog_cell_pkg::default_acc_width,
	localparam int cw = $clog2(cells_per_side),
	localparam int pw = cw + hog_cell_pkg::cell_px_bits,
	localparam int bw = $clog2(num_bins),
	localparam int half = (cells_per_side + 1) / 2,
	localparam int aw = $clog2(half * half * num_bins)
) (
	input logic aclk,
	input logic rst,
	input logic clear_start,
	input logic vote_valid,
	input logic [pw-1:0] vote_row,
	input logic [pw-1:0] vote_col,
	input logic [bw-1:0] vote_bin,
	input logic [acc_width-1:0] vote_intensity_0,
	input logic [acc_width-1:0] vote_intensity_1,
	input logic [acc_width-1:0] vote_intensity_2,
	input logic [acc_width-1:0] vote_intensity_3,
	input logic rd_valid,
	input logic [cw-1:0] rd_cell_row,
	input logic [cw-1:0] rd_cell_col,
	input logic [bw-1:0] rd_bin,
	output logic vote_ready,
	output logic rd_ready,
	output logic rd_resp_valid,
	output logic [acc_width-1:0] rd_resp_data,
	output logic hist_ready,
	output logic frame_done
);

	logic clear_en, clear_last, vote_accept, rd_accept;
	logic [aw-1:0] clear_addr, rd_addr;
	logic [aw-1:0] bank_addr [4];
	hog_cell_pkg::slot_e bank_slot [4];
	logic bank_slot_ok [4];
	hog_cell_pkg::bank_e rd_bank;
	logic [aw-1:0] bank_raddr [4], bank_waddr [4];
	logic bank_we [4];
	logic [acc_width-1:0] bank_wdata [4], bank_rdata [4];

	cell_hist_ctrl #(.cells_per_side(cells_per_side)) u_ctrl (
		.aclk, .rst, .clear_start, .clear_last, .vote_valid, .vote_row, .vote_col, .rd_valid,
		.clear_en, .vote_ready, .vote_accept, .rd_ready, .rd_accept, .hist_ready, .frame_done
	);

	clear_addr_counter #(.cells_per_side(cells_per_side), .num_bins(num_bins)) u_clear (
		.aclk, .rst, .clear_en, .clear_addr, .clear_last
	);

	vote_addr_gen #(.cells_per_side(cells_per_side), .num_bins(num_bins)) u_addr (
		.vote_row, .vote_col, .vote_bin, .rd_cell_row, .rd_cell_col, .rd_bin,
		.bank_addr_0(bank_addr[0]), .bank_addr_1(bank_addr[1]),
		.bank_addr_2(bank_addr[2]), .bank_addr_3(bank_addr[3]),
		.bank_slot_0(bank_slot[0]), .bank_slot_1(bank_slot[1]),
		.bank_slot_2(bank_slot[2]), .bank_slot_3(bank_slot[3]),
		.bank_slot_ok_0(bank_slot_ok[0]), .bank_slot_ok_1(bank_slot_ok[1]),
		.bank_slot_ok_2(bank_slot_ok[2]), .bank_slot_ok_3(bank_slot_ok[3]),
		.rd_bank, .rd_addr
	);

	vote_accumulate #(
		.cells_per_side(cells_per_side), .num_bins(num_bins), .acc_width(acc_width)
	) u_acc (
		.aclk, .rst, .vote_accept, .rd_accept, .clear_en, .clear_addr,
		.bank_addr_0(bank_addr[0]), .bank_addr_1(bank_addr[1]),
		.bank_addr_2(bank_addr[2]), .bank_addr_3(bank_addr[3]),
		.bank_slot_0(bank_slot[0]), .bank_slot_1(bank_slot[1]),
		.bank_slot_2(bank_slot[2]), .bank_slot_3(bank_slot[3]),
		.bank_slot_ok_0(bank_slot_ok[0]), .bank_slot_ok_1(bank_slot_ok[1]),
		.bank_slot_ok_2(bank_slot_ok[2]), .bank_slot_ok_3(bank_slot_ok[3]),
		.vote_intensity_0, .vote_intensity_1, .vote_intensity_2, .vote_intensity_3,
		.rd_bank, .rd_addr,
		.bank_rdata_0(bank_rdata[0]), .bank_rdata_1(bank_rdata[1]),
		.bank_rdata_2(bank_rdata[2]), .bank_rdata_3(bank_rdata[3]),
		.bank_raddr_0(bank_raddr[0]), .bank_raddr_1(bank_raddr[1]),
		.bank_raddr_2(bank_raddr[2]), .bank_raddr_3(bank_raddr[3]),
		.bank_we_0(bank_we[0]), .bank_we_1(bank_we[1]),
		.bank_we_2(bank_we[2]), .bank_we_3(bank_we[3]),
		.bank_waddr_0(bank_waddr[0]), .bank_waddr_1(bank_waddr[1]),
		.bank_waddr_2(bank_waddr[2]), .bank_waddr_3(bank_waddr[3]),
		.bank_wdata_0(bank_wdata[0]), .bank_wdata_1(bank_wdata[1]),
		.bank_wdata_2(bank_wdata[2]), .bank_wdata_3(bank_wdata[3]),
		.rd_resp_valid, .rd_resp_data
	);

	// banks indexed by hog_cell_pkg::bank_e
	for (genvar b = 0; b < 4; b++) begin : g_bank
		hist_bank #(
			.cells_per_side(cells_per_side), .num_bins(num_bins), .acc_width(acc_width)
		) u_bank (
			.aclk, .raddr(bank_raddr[b]), .we(bank_we[b]), .waddr(bank_waddr[b]),
			.wdata(bank_wdata[b]), .rdata(bank_rdata[b])
		);
	end

endmodule

//--- testbench/cell_hist_checker.sv
// concurrent handshake and pulse assertions for the cell-histogram top, attached with bind
`timescale 1ns/1ps

module cell_hist_checker #(
	parameter int cells_per_side = hog_cell_pkg::default_cells_per_side,
	localparam int pw = $clog2(cells_per_side) + hog_cell_pkg::cell_px_bits
) (
	input logic aclk,
	input logic rst,
	input logic clear_start,
	input logic vote_valid,
	input logic vote_ready,
	input logic [pw-1:0] vote_row,
	input logic [pw-1:0] vote_col,
	input logic rd_valid,
	input logic rd_ready,
	input logic rd_resp_valid,
	input logic hist_ready,
	input logic frame_done
);

	localparam int px_per_side = cells_per_side * (1 << hog_cell_pkg::cell_px_bits);
	localparam logic [pw-1:0] last_px = pw'(px_per_side - 1);

	int fail_count = 0; // read by the bench at the end
	logic vote_last; // last-pixel vote transfers
	logic rd_acc; // readback transfers

	assign vote_last = vote_valid & vote_ready & (vote_row == last_px) & (vote_col == last_px);
	assign rd_acc = rd_valid & rd_ready;

	//--------------------------------------------------
	// handshake and pulse timing
	//--------------------------------------------------
	no_ready_before_hist: assert property (@(posedge aclk) disable iff (rst)
		!hist_ready |-> !vote_ready && !rd_ready)
		else begin
			$error("vote_ready or rd_ready was high before hist_ready");
			fail_count++;
		end

	frame_done_pulse: assert property (@(posedge aclk) disable iff (rst)
		vote_last |-> ##2 frame_done ##1 !frame_done)
		else begin
			$error("frame_done was not a one-cycle pulse two edges after the last-pixel vote");
			fail_count++;
		end

	frame_done_cause: assert property (@(posedge aclk) disable iff (rst)
		frame_done |-> $past(vote_last, 2))
		else begin
			$error("frame_done rose without a last-pixel vote two edges before");
			fail_count++;
		end

	rd_resp_timing: assert property (@(posedge aclk) disable iff (rst)
		rd_acc |-> ##2 rd_resp_valid)
		else begin
			$error("rd_resp_valid did not follow a readback two edges after it");
			fail_count++;
		end

	rd_resp_cause: assert property (@(posedge aclk) disable iff (rst)
		rd_resp_valid |-> $past(rd_acc, 2))
		else begin
			$error("rd_resp_valid rose without a readback two edges before");
			fail_count++;
		end

	clear_drops_ready: assert property (@(posedge aclk) disable iff (rst)
		vote_ready && clear_start |=> !vote_ready)
		else begin
			$error("vote_ready stayed high after clear_start in idle");
			fail_count++;
		end

endmodule

bind cell_hist_top cell_hist_checker #(.cells_per_side(cells_per_side)) u_checker (.*);

//--- testbench/cell_hist_tb.sv
// testbench for the cell-histogram top, random votes against a reference model and full readback
`timescale 1ns/1ps

module cell_hist_tb;

	localparam int cps = 6; // cells per side
	localparam int nb = 4; // bins
	localparam int acw = 16; // accumulator width
	localparam int cw = $clog2(cps);
	localparam int pb = hog_cell_pkg::cell_px_bits;
	localparam int pw = cw + pb;
	localparam int bw = $clog2(nb);
	localparam int px_max = cps * (1 << pb) - 1; // last pixel row and col
	localparam int n_rand = 300; // random votes
	localparam int clear_len = ((cps + 1) / 2) * ((cps + 1) / 2) * nb;
	localparam int n_reads = cps * cps * nb; // one full sweep
	localparam int timeout_ns = 10 * (3 * (n_rand + 20) + 3 * (clear_len + 5 * n_reads) + 100);

	logic aclk = 1'b0;
	logic rst, clear_start, vote_valid, rd_valid;
	logic [pw-1:0] vote_row, vote_col;
	logic [bw-1:0] vote_bin, rd_bin;
	logic [acw-1:0] vote_intensity_0, vote_intensity_1, vote_intensity_2, vote_intensity_3;
	logic [cw-1:0] rd_cell_row, rd_cell_col;
	logic vote_ready, rd_ready, rd_resp_valid, hist_ready, frame_done;
	logic [acw-1:0] rd_resp_data;

	logic [acw-1:0] model [cps][cps][nb]; // reference histogram, wraps like the DUT
	integer seed = 32'h7fc3_8896;
	int errors = 0;
	int checks = 0;

	cell_hist_top #(.cells_per_side(cps), .num_bins(nb), .acc_width(acw)) UUT (
		.aclk, .rst, .clear_start, .vote_valid, .vote_row, .vote_col, .vote_bin,
		.vote_intensity_0, .vote_intensity_1, .vote_intensity_2, .vote_intensity_3,
		.rd_valid, .rd_cell_row, .rd_cell_col, .rd_bin,
		.vote_ready, .rd_ready, .rd_resp_valid, .rd_resp_data, .hist_ready, .frame_done
	);

	always #5 aclk = ~aclk; // 10 ns period

	//--------------------------------------------------
	// reference model
	//--------------------------------------------------
	function automatic bit on_grid(input int r, input int c);
		return (r >= 0) && (r < cps) && (c >= 0) && (c < cps);
	endfunction

	task automatic zero_model();
		foreach (model[r, c, b]) model[r][c][b] = '0;
	endtask

	task automatic add_vote(input int row, input int col, input int bin, input logic [acw-1:0] i0,
			input logic [acw-1:0] i1, input logic [acw-1:0] i2, input logic [acw-1:0] i3);
		int cr, cc, nr, nc;
		cr = row >> pb;
		cc = col >> pb;
		nr = (row % (1 << pb) < (1 << (pb - 1))) ? cr - 1 : cr + 1; // upper half looks up
		nc = (col % (1 << pb) < (1 << (pb - 1))) ? cc - 1 : cc + 1; // left half looks left
		model[cr][cc][bin] += i0;
		if (on_grid(nr, cc)) model[nr][cc][bin] += i1;
		if (on_grid(nr, nc)) model[nr][nc][bin] += i2;
		if (on_grid(cr, nc)) model[cr][nc][bin] += i3;
	endtask

	//--------------------------------------------------
	// stimulus tasks
	//--------------------------------------------------
	task automatic send_vote(input int row, input int col, input int bin);
		logic [acw-1:0] i [4];
		foreach (i[k]) i[k] = acw'($random(seed));
		vote_valid <= 1'b1;
		vote_row <= pw'(row);
		vote_col <= pw'(col);
		vote_bin <= bw'(bin);
		vote_intensity_0 <= i[0];
		vote_intensity_1 <= i[1];
		vote_intensity_2 <= i[2];
		vote_intensity_3 <= i[3];
		@(posedge aclk);
		while (!vote_ready) @(posedge aclk); // transfer at this edge
		add_vote(row, col, bin, i[0], i[1], i[2], i[3]);
	endtask

	task automatic stop_votes();
		vote_valid <= 1'b0;
		repeat (3) @(posedge aclk); // let the last write land
	endtask

	task automatic read_and_compare(input int r, input int c, input int b);
		rd_valid <= 1'b1;
		rd_cell_row <= cw'(r);
		rd_cell_col <= cw'(c);
		rd_bin <= bw'(b);
		@(posedge aclk);
		while (!rd_ready) @(posedge aclk);
		rd_valid <= 1'b0; // fields held until the response
		@(posedge aclk);
		while (!rd_resp_valid) @(posedge aclk);
		checks++;
		assert (rd_resp_data == model[r][c][b]) else begin
			errors++;
			$display("Error: rd_resp_data cell %0d,%0d bin %0d got 0x%h expected 0x%h",
				r, c, b, rd_resp_data, model[r][c][b]);
		end
	endtask

	task automatic read_all();
		for (int r = 0; r < cps; r++)
			for (int c = 0; c < cps; c++)
				for (int b = 0; b < nb; b++) read_and_compare(r, c, b);
	endtask

	task automatic wait_hist_ready();
		@(posedge aclk);
		while (!hist_ready) @(posedge aclk);
	endtask

	//--------------------------------------------------
	// test sequence
	//--------------------------------------------------
	initial begin : stimulus
		int r, c;
		rst = 1'b1;
		clear_start = 1'b0;
		vote_valid = 1'b0;
		vote_row = '0;
		vote_col = '0;
		vote_bin = '0;
		vote_intensity_0 = '0;
		vote_intensity_1 = '0;
		vote_intensity_2 = '0;
		vote_intensity_3 = '0;
		rd_valid = 1'b0;
		rd_cell_row = '0;
		rd_cell_col = '0;
		rd_bin = '0;
		repeat (3) @(posedge aclk);
		rst <= 1'b0;
		wait_hist_ready(); // power-up clear
		zero_model();
		read_all();
		send_vote(0, 0, 0); // corners, last one raises frame_done
		send_vote(0, px_max, 1);
		send_vote(px_max, 0, 2);
		send_vote(px_max, px_max, 3);
		repeat (3) send_vote(9, 14, 1); // same word back to back
		send_vote(5, 5, 2); // these share two cells
		send_vote(5, 9, 2);
		send_vote(5, 5, 2);
		for (int n = 0; n < n_rand; n++) begin
			r = $unsigned($random(seed)) % (px_max + 1);
			c = $unsigned($random(seed)) % (px_max + 1);
			if (r == px_max && c == px_max) c = px_max - 1; // one frame_done at a time
			if (($random(seed) & 7) == 0) begin
				vote_valid <= 1'b0; // idle gap
				@(posedge aclk);
			end
			send_vote(r, c, $unsigned($random(seed)) % nb);
		end
		stop_votes();
		read_all();
		clear_start <= 1'b1; // re-clear from idle
		@(posedge aclk);
		clear_start <= 1'b0;
		wait_hist_ready();
		zero_model();
		read_all();
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
			UUT.u_checker.fail_count);
		if (errors == 0 && UUT.u_checker.fail_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial begin : watchdog
		#(timeout_ns);
		$display("timeout, the run did not finish within %0d ns, errors %0d", timeout_ns, errors);
		$display("Test failed");
		$finish;
	end

endmodule

//--- sources.f
src/hog_cell_pkg.sv
src/hist_bank.sv
src/clear_addr_counter.sv
src/cell_hist_ctrl.sv
src/vote_addr_gen.sv
src/vote_accumulate.sv
src/cell_hist_top.sv
testbench/cell_hist_checker.sv
testbench/cell_hist_tb.sv

//--- Bender.yml
package:
  name: cell_hist

sources:
  - src/hog_cell_pkg.sv
  - src/hist_bank.sv
  - src/clear_addr_counter.sv
  - src/cell_hist_ctrl.sv
  - src/vote_addr_gen.sv
  - src/vote_accumulate.sv
  - src/cell_hist_top.sv
  - target: test
    files:
      - testbench/cell_hist_checker.sv
      - testbench/cell_hist_tb.sv
